/* verilog/core_pkg.sv */
// shared types, opcode and funct constants, alu op enum for the rv64 core
package core_pkg;

  localparam int XLEN = 64;

  // widths that carry a meaning
  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [XLEN-1:0] pc_t;
  typedef logic [31:0]     inst_t;
  typedef logic [31:0]     sram_addr_t;
  // two instructions per sram word
  typedef logic [63:0]     sram_data_t;
  typedef logic [4:0]      reg_idx_t;

  // execute operation
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B,
    ALU_LINK
  } alu_op_e;

  localparam pc_t PC_RESET = '0;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // funct3 / funct7 for the supported subset
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

endpackage

/* verilog/fetch_stage.sv */
// fetch stage: pc register, next-pc mux, instruction sram request, handshake to decode
`timescale 1ns/1ns

module fetch_stage import core_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_ds_allowin,
  input  logic       i_br_taken,
  input  pc_t        i_br_target,
  input  sram_data_t i_inst_sram_rdata,
  output logic       o_fs_to_ds_valid,
  output pc_t        o_fs_pc,
  output inst_t      o_fs_inst,
  output logic       o_inst_sram_ren,
  output sram_addr_t o_inst_sram_addr
);

  logic fs_valid;
  logic fs_allowin;
  pc_t  fs_pc;
  pc_t  seq_pc;
  pc_t  nextpc;

  // sram data is back while fetch holds the pc, no wait state
  // empty, or current instruction moves on this cycle
  assign fs_allowin  = !fs_valid || i_ds_allowin;
  // wrong-path instruction dropped when decode redirects
  assign o_fs_to_ds_valid = fs_valid && !i_br_taken;

  // pre-fetch pc mux
  assign seq_pc = fs_pc + pc_t'(4);
  assign nextpc = i_br_taken ? i_br_target : seq_pc;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      fs_valid <= 1'b0;
      // one word before reset pc, so first fetch lands on PC_RESET
      fs_pc    <= PC_RESET - pc_t'(4);
    end else if (fs_allowin) begin
      fs_valid <= 1'b1;
      fs_pc    <= nextpc;
    end
  end

  // read issued in the cycle the pc is loaded
  assign o_inst_sram_ren  = fs_allowin;
  assign o_inst_sram_addr = nextpc[31:0];

  // 64-bit word, pc[2] picks the half
  assign o_fs_inst = fs_pc[2] ? i_inst_sram_rdata[63:32] : i_inst_sram_rdata[31:0];
  assign o_fs_pc   = fs_pc;

  a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    fs_pc[1:0] == 2'b00);

endmodule

/* verilog/reg_file.sv */
// 32 x 64 register file, two combinational read ports, one write port
`timescale 1ns/1ns

module reg_file import core_pkg::*; (
  input  logic     i_clk,
  input  reg_idx_t i_raddr1,
  input  reg_idx_t i_raddr2,
  input  logic     i_we,
  input  reg_idx_t i_waddr,
  input  xlen_t    i_wdata,
  output xlen_t    o_rdata1,
  output xlen_t    o_rdata2
);

  // x0 has no storage
  xlen_t regs [1:31];

  always_ff @(posedge i_clk) begin
    if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 reads as zero
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* verilog/decode_stage.sv */
// decode stage: field decode, operand read, branch resolution, scoreboard stall
`timescale 1ns/1ns

module decode_stage import core_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_fs_to_ds_valid,
  input  pc_t      i_fs_pc,
  input  inst_t    i_fs_inst,
  input  logic     i_es_allowin,
  input  reg_idx_t i_es_dest,
  input  logic     i_es_dest_valid,
  input  reg_idx_t i_ws_dest,
  input  logic     i_ws_dest_valid,
  input  xlen_t    i_rdata1,
  input  xlen_t    i_rdata2,
  output logic     o_ds_allowin,
  output logic     o_br_taken,
  output pc_t      o_br_target,
  output reg_idx_t o_raddr1,
  output reg_idx_t o_raddr2,
  output logic     o_ds_to_es_valid,
  output pc_t      o_ds_pc,
  output alu_op_e  o_ds_alu_op,
  output xlen_t    o_ds_src_a,
  output xlen_t    o_ds_src_b,
  output reg_idx_t o_ds_rd,
  output logic     o_ds_we
);

  logic       ds_valid;
  logic       ds_ready_go;
  pc_t        ds_pc;
  inst_t      ds_inst;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  xlen_t      imm_i;
  xlen_t      imm_u;
  xlen_t      imm_b;
  xlen_t      imm_j;
  logic       is_op;
  logic       is_add;
  logic       is_sub;
  logic       is_xor;
  logic       is_or;
  logic       is_and;
  logic       is_alu_rr;
  logic       is_addi;
  logic       is_lui;
  logic       is_beq;
  logic       is_bne;
  logic       is_jal;
  logic       use_rs1;
  logic       use_rs2;
  logic       rs1_hit;
  logic       rs2_hit;
  logic       hazard;
  logic       src_eq;

  assign o_ds_allowin = !ds_valid || (ds_ready_go && i_es_allowin);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
    // payload only, no reset
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_pc   <= i_fs_pc;
      ds_inst <= i_fs_inst;
    end
  end

  // instruction fields
  assign opcode = ds_inst[6:0];
  assign funct3 = ds_inst[14:12];
  assign funct7 = ds_inst[31:25];
  assign rs1    = ds_inst[19:15];
  assign rs2    = ds_inst[24:20];

  // sign-extended immediates
  assign imm_i = {{52{ds_inst[31]}}, ds_inst[31:20]};
  assign imm_u = {{32{ds_inst[31]}}, ds_inst[31:12], 12'b0};
  assign imm_b = {{52{ds_inst[31]}}, ds_inst[7], ds_inst[30:25], ds_inst[11:8], 1'b0};
  assign imm_j = {{44{ds_inst[31]}}, ds_inst[19:12], ds_inst[20], ds_inst[30:21], 1'b0};

  // supported subset, anything else falls through as a no-op
  assign is_op     = opcode == OPC_OP;
  assign is_add    = is_op && funct7 == F7_BASE && funct3 == F3_ADD_SUB;
  assign is_sub    = is_op && funct7 == F7_SUB && funct3 == F3_ADD_SUB;
  assign is_xor    = is_op && funct7 == F7_BASE && funct3 == F3_XOR;
  assign is_or     = is_op && funct7 == F7_BASE && funct3 == F3_OR;
  assign is_and    = is_op && funct7 == F7_BASE && funct3 == F3_AND;
  assign is_alu_rr = is_add || is_sub || is_xor || is_or || is_and;
  assign is_addi   = opcode == OPC_OP_IMM && funct3 == F3_ADD_SUB;
  assign is_lui    = opcode == OPC_LUI;
  assign is_beq    = opcode == OPC_BRANCH && funct3 == F3_BEQ;
  assign is_bne    = opcode == OPC_BRANCH && funct3 == F3_BNE;
  assign is_jal    = opcode == OPC_JAL;

  // source uses by opcode, lui and jal read nothing
  assign use_rs1 = is_alu_rr || is_addi || is_beq || is_bne;
  assign use_rs2 = is_alu_rr || is_beq || is_bne;

  // scoreboard against execute and result, x0 never pending
  assign rs1_hit = use_rs1 && rs1 != '0 &&
                   ((i_es_dest_valid && i_es_dest == rs1) ||
                    (i_ws_dest_valid && i_ws_dest == rs1));
  assign rs2_hit = use_rs2 && rs2 != '0 &&
                   ((i_es_dest_valid && i_es_dest == rs2) ||
                    (i_ws_dest_valid && i_ws_dest == rs2));
  assign hazard      = rs1_hit || rs2_hit;
  assign ds_ready_go = !hazard;

  assign o_raddr1 = rs1;
  assign o_raddr2 = rs2;

  // branch resolved here, redirect only when the branch leaves decode
  assign src_eq      = i_rdata1 == i_rdata2;
  assign o_br_taken  = ds_valid && ds_ready_go && i_es_allowin &&
                       (is_jal || (is_beq && src_eq) || (is_bne && !src_eq));
  assign o_br_target = ds_pc + (is_jal ? imm_j : imm_b);

  always_comb begin
    o_ds_alu_op = ALU_ADD;
    if (is_sub) o_ds_alu_op = ALU_SUB;
    else if (is_and) o_ds_alu_op = ALU_AND;
    else if (is_or) o_ds_alu_op = ALU_OR;
    else if (is_xor) o_ds_alu_op = ALU_XOR;
    else if (is_lui) o_ds_alu_op = ALU_PASS_B;
    else if (is_jal) o_ds_alu_op = ALU_LINK;
  end

  // operand b: immediate for addi/lui, register otherwise
  assign o_ds_src_a = i_rdata1;
  assign o_ds_src_b = is_addi ? imm_i : (is_lui ? imm_u : i_rdata2);

  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  assign o_ds_pc          = ds_pc;
  assign o_ds_rd          = ds_inst[11:7];
  // branches and no-ops write nothing
  assign o_ds_we          = is_alu_rr || is_addi || is_lui || is_jal;

  // a stalled instruction stays in decode until the scoreboard clears
  a_hold_on_hazard: assert property (@(posedge i_clk) disable iff (i_rst)
    ds_valid && hazard |=> ds_valid && $stable(ds_pc) && $stable(ds_inst));

endmodule

/* verilog/execute_stage.sv */
// execute stage: alu, link address, pipeline register toward result
`timescale 1ns/1ns

module execute_stage import core_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_ds_to_es_valid,
  input  pc_t      i_ds_pc,
  input  alu_op_e  i_ds_alu_op,
  input  xlen_t    i_ds_src_a,
  input  xlen_t    i_ds_src_b,
  input  reg_idx_t i_ds_rd,
  input  logic     i_ds_we,
  input  logic     i_ws_allowin,
  output logic     o_es_allowin,
  output reg_idx_t o_es_dest,
  output logic     o_es_dest_valid,
  output logic     o_es_to_ws_valid,
  output pc_t      o_es_pc,
  output xlen_t    o_es_result,
  output reg_idx_t o_es_rd,
  output logic     o_es_we
);

  logic     es_valid;
  pc_t      es_pc;
  alu_op_e  es_alu_op;
  xlen_t    es_src_a;
  xlen_t    es_src_b;
  reg_idx_t es_rd;
  logic     es_we;

  // single-cycle alu, always ready to go
  assign o_es_allowin = !es_valid || i_ws_allowin;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      es_valid <= 1'b0;
    end else if (o_es_allowin) begin
      // bubble when decode stalls
      es_valid <= i_ds_to_es_valid;
    end
    if (i_ds_to_es_valid && o_es_allowin) begin
      es_pc     <= i_ds_pc;
      es_alu_op <= i_ds_alu_op;
      es_src_a  <= i_ds_src_a;
      es_src_b  <= i_ds_src_b;
      es_rd     <= i_ds_rd;
      es_we     <= i_ds_we;
    end
  end

  always_comb begin
    case (es_alu_op)
      ALU_SUB:    o_es_result = es_src_a - es_src_b;
      ALU_AND:    o_es_result = es_src_a & es_src_b;
      ALU_OR:     o_es_result = es_src_a | es_src_b;
      ALU_XOR:    o_es_result = es_src_a ^ es_src_b;
      // lui immediate already shifted in decode
      ALU_PASS_B: o_es_result = es_src_b;
      // jal return address
      ALU_LINK:   o_es_result = es_pc + xlen_t'(4);
      default:    o_es_result = es_src_a + es_src_b;
    endcase
  end

  // scoreboard view
  assign o_es_dest       = es_rd;
  assign o_es_dest_valid = es_valid && es_we;

  assign o_es_to_ws_valid = es_valid;
  assign o_es_pc          = es_pc;
  assign o_es_rd          = es_rd;
  assign o_es_we          = es_we;

endmodule

/* verilog/result_stage.sv */
// result stage: register file write, scoreboard clear, commit port
`timescale 1ns/1ns

module result_stage import core_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_es_to_ws_valid,
  input  pc_t      i_es_pc,
  input  xlen_t    i_es_result,
  input  reg_idx_t i_es_rd,
  input  logic     i_es_we,
  output logic     o_ws_allowin,
  output reg_idx_t o_ws_dest,
  output logic     o_ws_dest_valid,
  output logic     o_rf_we,
  output reg_idx_t o_rf_waddr,
  output xlen_t    o_rf_wdata,
  output logic     o_commit_valid,
  output pc_t      o_commit_pc,
  output logic     o_commit_we,
  output reg_idx_t o_commit_rd,
  output xlen_t    o_commit_wdata
);

  logic     ws_valid;
  pc_t      ws_pc;
  xlen_t    ws_result;
  reg_idx_t ws_rd;
  logic     ws_we;

  // retires every cycle, never back-pressures
  assign o_ws_allowin = 1'b1;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ws_valid <= 1'b0;
    end else begin
      ws_valid <= i_es_to_ws_valid;
    end
    if (i_es_to_ws_valid) begin
      ws_pc     <= i_es_pc;
      ws_result <= i_es_result;
      ws_rd     <= i_es_rd;
      ws_we     <= i_es_we;
    end
  end

  // pending until the write edge at the end of this cycle
  assign o_ws_dest       = ws_rd;
  assign o_ws_dest_valid = ws_valid && ws_we;

  // x0 writes dropped
  assign o_rf_we    = ws_valid && ws_we && (ws_rd != '0);
  assign o_rf_waddr = ws_rd;
  assign o_rf_wdata = ws_result;

  assign o_commit_valid = ws_valid;
  assign o_commit_pc    = ws_pc;
  assign o_commit_we    = o_rf_we;
  assign o_commit_rd    = ws_rd;
  assign o_commit_wdata = ws_result;

  // an x0 destination handed over by execute never reaches the register file
  a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_rst)
    i_es_to_ws_valid && i_es_we && i_es_rd == '0 |=> !o_rf_we);

endmodule

/* verilog/core_top.sv */
// core top: four pipeline stages and the register file, sram and commit ports
`timescale 1ns/1ns

module core_top import core_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst,
  input  sram_data_t i_inst_sram_rdata,
  output logic       o_inst_sram_ren,
  output sram_addr_t o_inst_sram_addr,
  output logic       o_commit_valid,
  output pc_t        o_commit_pc,
  output logic       o_commit_we,
  output reg_idx_t   o_commit_rd,
  output xlen_t      o_commit_wdata
);

  // fetch <-> decode
  logic     ds_allowin;
  logic     fs_to_ds_valid;
  pc_t      fs_pc;
  inst_t    fs_inst;
  logic     br_taken;
  pc_t      br_target;
  // decode <-> register file
  reg_idx_t raddr1;
  reg_idx_t raddr2;
  xlen_t    rdata1;
  xlen_t    rdata2;
  // decode <-> execute
  logic     es_allowin;
  logic     ds_to_es_valid;
  pc_t      ds_pc;
  alu_op_e  ds_alu_op;
  xlen_t    ds_src_a;
  xlen_t    ds_src_b;
  reg_idx_t ds_rd;
  logic     ds_we;
  // execute <-> result
  logic     ws_allowin;
  logic     es_to_ws_valid;
  pc_t      es_pc;
  xlen_t    es_result;
  reg_idx_t es_rd;
  logic     es_we;
  // scoreboard taps
  reg_idx_t es_dest;
  logic     es_dest_valid;
  reg_idx_t ws_dest;
  logic     ws_dest_valid;
  // write-back
  logic     rf_we;
  reg_idx_t rf_waddr;
  xlen_t    rf_wdata;

  fetch_stage u_fetch (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_ds_allowin      (ds_allowin),
    .i_br_taken        (br_taken),
    .i_br_target       (br_target),
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .o_fs_to_ds_valid  (fs_to_ds_valid),
    .o_fs_pc           (fs_pc),
    .o_fs_inst         (fs_inst),
    .o_inst_sram_ren   (o_inst_sram_ren),
    .o_inst_sram_addr  (o_inst_sram_addr)
  );

  decode_stage u_decode (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_fs_pc          (fs_pc),
    .i_fs_inst        (fs_inst),
    .i_es_allowin     (es_allowin),
    .i_es_dest        (es_dest),
    .i_es_dest_valid  (es_dest_valid),
    .i_ws_dest        (ws_dest),
    .i_ws_dest_valid  (ws_dest_valid),
    .i_rdata1         (rdata1),
    .i_rdata2         (rdata2),
    .o_ds_allowin     (ds_allowin),
    .o_br_taken       (br_taken),
    .o_br_target      (br_target),
    .o_raddr1         (raddr1),
    .o_raddr2         (raddr2),
    .o_ds_to_es_valid (ds_to_es_valid),
    .o_ds_pc          (ds_pc),
    .o_ds_alu_op      (ds_alu_op),
    .o_ds_src_a       (ds_src_a),
    .o_ds_src_b       (ds_src_b),
    .o_ds_rd          (ds_rd),
    .o_ds_we          (ds_we)
  );

  reg_file u_reg_file (
    .i_clk    (i_clk),
    .i_raddr1 (raddr1),
    .i_raddr2 (raddr2),
    .i_we     (rf_we),
    .i_waddr  (rf_waddr),
    .i_wdata  (rf_wdata),
    .o_rdata1 (rdata1),
    .o_rdata2 (rdata2)
  );

  execute_stage u_execute (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_ds_to_es_valid (ds_to_es_valid),
    .i_ds_pc          (ds_pc),
    .i_ds_alu_op      (ds_alu_op),
    .i_ds_src_a       (ds_src_a),
    .i_ds_src_b       (ds_src_b),
    .i_ds_rd          (ds_rd),
    .i_ds_we          (ds_we),
    .i_ws_allowin     (ws_allowin),
    .o_es_allowin     (es_allowin),
    .o_es_dest        (es_dest),
    .o_es_dest_valid  (es_dest_valid),
    .o_es_to_ws_valid (es_to_ws_valid),
    .o_es_pc          (es_pc),
    .o_es_result      (es_result),
    .o_es_rd          (es_rd),
    .o_es_we          (es_we)
  );

  result_stage u_result (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_es_to_ws_valid (es_to_ws_valid),
    .i_es_pc          (es_pc),
    .i_es_result      (es_result),
    .i_es_rd          (es_rd),
    .i_es_we          (es_we),
    .o_ws_allowin     (ws_allowin),
    .o_ws_dest        (ws_dest),
    .o_ws_dest_valid  (ws_dest_valid),
    .o_rf_we          (rf_we),
    .o_rf_waddr       (rf_waddr),
    .o_rf_wdata       (rf_wdata),
    .o_commit_valid   (o_commit_valid),
    .o_commit_pc      (o_commit_pc),
    .o_commit_we      (o_commit_we),
    .o_commit_rd      (o_commit_rd),
    .o_commit_wdata   (o_commit_wdata)
  );

endmodule

/* dv/core_tb.sv */
// testbench for core_top: clock, reset, instruction memory, random program, isa model, checks
`timescale 1ns/1ns

module core_tb import core_pkg::*; ();

  localparam int N_COMMITS      = 400;
  // worst case 4 cycles per commit, doubled for stall slack
  localparam int TIMEOUT_CYCLES = N_COMMITS * 8;
  localparam int N_SLOTS        = 64;
  localparam int SEED           = 10364;

  // program slot kinds
  localparam int K_ADD   = 0;
  localparam int K_SUB   = 1;
  localparam int K_AND   = 2;
  localparam int K_OR    = 3;
  localparam int K_XOR   = 4;
  localparam int K_ADDI  = 5;
  localparam int K_LUI   = 6;
  localparam int K_BEQ   = 7;
  localparam int K_BNE   = 8;
  localparam int K_JAL   = 9;
  localparam int K_UNDEF = 10;

  logic       clk;
  logic       rst;
  sram_data_t inst_sram_rdata = '0;
  logic       inst_sram_ren;
  sram_addr_t inst_sram_addr;
  logic       commit_valid;
  pc_t        commit_pc;
  logic       commit_we;
  reg_idx_t   commit_rd;
  xlen_t      commit_wdata;

  // program as encoded words plus the fields the model works from
  inst_t      prog  [N_SLOTS];
  int         kind  [N_SLOTS];
  reg_idx_t   f_rd  [N_SLOTS];
  reg_idx_t   f_rs1 [N_SLOTS];
  reg_idx_t   f_rs2 [N_SLOTS];
  xlen_t      f_imm [N_SLOTS];
  sram_data_t imem  [32];

  // isa model state
  pc_t        m_pc;
  xlen_t      m_regs [32];

  logic       req_pending = 1'b0;
  sram_addr_t req_addr    = '0;
  int         err_count   = 0;
  int         commit_count = 0;
  int         cycle_count = 0;

  core_top dut_i (
    .i_clk             (clk),
    .i_rst             (rst),
    .i_inst_sram_rdata (inst_sram_rdata),
    .o_inst_sram_ren   (inst_sram_ren),
    .o_inst_sram_addr  (inst_sram_addr),
    .o_commit_valid    (commit_valid),
    .o_commit_pc       (commit_pc),
    .o_commit_we       (commit_we),
    .o_commit_rd       (commit_rd),
    .o_commit_wdata    (commit_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // instruction encoders
  function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic inst_t enc_b(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic inst_t enc_j(logic [20:0] off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // mostly x0..x7 so hazards come often
  function automatic reg_idx_t dest_reg();
    if ($urandom_range(0, 3) != 0) return reg_idx_t'($urandom_range(0, 7));
    return reg_idx_t'($urandom_range(0, 31));
  endfunction

  // sources stay on the registers the prologue sets up
  function automatic reg_idx_t src_reg();
    return reg_idx_t'($urandom_range(0, 7));
  endfunction

  task automatic build_program();
    int          slot;
    int          steps;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [31:0] junk;
    for (slot = 0; slot < N_SLOTS; slot++) begin
      f_rd[slot]  = dest_reg();
      f_rs1[slot] = src_reg();
      f_rs2[slot] = src_reg();
      imm12 = 12'($urandom());
      imm20 = 20'($urandom());
      junk  = $urandom();
      // branch offset, nonzero multiple of 4 within +-64
      steps = int'($urandom_range(1, 16));
      if ($urandom_range(0, 1) == 1) steps = -steps;
      if (slot < 7) begin
        // prologue: addi x1..x7 from x0
        kind[slot]  = K_ADDI;
        f_rd[slot]  = reg_idx_t'(slot + 1);
        f_rs1[slot] = '0;
      end else if ($urandom_range(0, 7) == 0) begin
        kind[slot] = K_UNDEF;
      end else begin
        kind[slot] = int'($urandom_range(K_ADD, K_JAL));
      end
      f_imm[slot] = '0;
      case (kind[slot])
        K_ADD: prog[slot] = enc_r(F7_BASE, f_rs2[slot], f_rs1[slot], F3_ADD_SUB, f_rd[slot]);
        K_SUB: prog[slot] = enc_r(F7_SUB, f_rs2[slot], f_rs1[slot], F3_ADD_SUB, f_rd[slot]);
        K_AND: prog[slot] = enc_r(F7_BASE, f_rs2[slot], f_rs1[slot], F3_AND, f_rd[slot]);
        K_OR:  prog[slot] = enc_r(F7_BASE, f_rs2[slot], f_rs1[slot], F3_OR, f_rd[slot]);
        K_XOR: prog[slot] = enc_r(F7_BASE, f_rs2[slot], f_rs1[slot], F3_XOR, f_rd[slot]);
        K_ADDI: begin
          f_imm[slot] = {{52{imm12[11]}}, imm12};
          prog[slot]  = {imm12, f_rs1[slot], F3_ADD_SUB, f_rd[slot], OPC_OP_IMM};
        end
        K_LUI: begin
          f_imm[slot] = {{32{imm20[19]}}, imm20, 12'h000};
          prog[slot]  = {imm20, f_rd[slot], OPC_LUI};
        end
        K_BEQ, K_BNE: begin
          f_imm[slot] = xlen_t'(longint'(steps * 4));
          prog[slot]  = enc_b(f_imm[slot][12:0], f_rs2[slot], f_rs1[slot],
                              (kind[slot] == K_BEQ) ? F3_BEQ : F3_BNE);
        end
        K_JAL: begin
          f_imm[slot] = xlen_t'(longint'(steps * 4));
          prog[slot]  = enc_j(f_imm[slot][20:0], f_rd[slot]);
        end
        // opcode 7'h7f decodes as nothing
        default: prog[slot] = {junk[31:7], 7'b1111111};
      endcase
    end
    // two instructions per doubleword, low half first
    for (slot = 0; slot < 32; slot++) begin
      imem[slot] = {prog[2 * slot + 1], prog[2 * slot]};
    end
  endtask

  task automatic report_mismatch(string name, xlen_t got, xlen_t exp);
    err_count++;
    $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
  endtask

  // one retired instruction through the model, compared with the commit port
  task automatic check_commit();
    int    slot;
    xlen_t a;
    xlen_t b;
    xlen_t val;
    logic  wr;
    pc_t   nxt;
    // same 256-byte wrap as the memory
    slot = int'(m_pc[7:2]);
    a    = m_regs[f_rs1[slot]];
    b    = m_regs[f_rs2[slot]];
    wr   = 1'b1;
    val  = '0;
    nxt  = m_pc + pc_t'(4);
    case (kind[slot])
      K_ADD:  val = a + b;
      K_SUB:  val = a - b;
      K_AND:  val = a & b;
      K_OR:   val = a | b;
      K_XOR:  val = a ^ b;
      K_ADDI: val = a + f_imm[slot];
      K_LUI:  val = f_imm[slot];
      K_BEQ: begin
        wr = 1'b0;
        if (a == b) nxt = m_pc + f_imm[slot];
      end
      K_BNE: begin
        wr = 1'b0;
        if (a != b) nxt = m_pc + f_imm[slot];
      end
      K_JAL: begin
        val = m_pc + pc_t'(4);
        nxt = m_pc + f_imm[slot];
      end
      default: wr = 1'b0;
    endcase
    // x0 never written
    if (f_rd[slot] == '0) wr = 1'b0;

    assert (commit_pc === m_pc)
      else report_mismatch("o_commit_pc", commit_pc, m_pc);
    assert (commit_we === wr)
      else report_mismatch("o_commit_we", xlen_t'(commit_we), xlen_t'(wr));
    if (wr) begin
      assert (commit_rd === f_rd[slot])
        else report_mismatch("o_commit_rd", xlen_t'(commit_rd), xlen_t'(f_rd[slot]));
      assert (commit_wdata === val)
        else report_mismatch("o_commit_wdata", commit_wdata, val);
      m_regs[f_rd[slot]] = val;
    end
    m_pc = nxt;
  endtask

  // sram: request seen in one cycle, data driven after the next rising edge
  always @(negedge clk) begin
    if (req_pending) begin
      inst_sram_rdata = imem[req_addr[7:3]];
    end
    req_pending = inst_sram_ren;
    req_addr    = inst_sram_addr;
  end

  // commit monitor, outputs stable at the falling edge
  always @(negedge clk) begin
    if (commit_valid === 1'b1) begin
      check_commit();
      commit_count++;
    end
  end

  initial begin
    int i;
    rst = 1'b1;
    void'($urandom(SEED));
    build_program();
    m_pc = PC_RESET;
    for (i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end

    // two cycles of reset, commit port must stay quiet
    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      assert (commit_valid === 1'b0)
        else report_mismatch("o_commit_valid", xlen_t'(commit_valid), '0);
    end
    rst = 1'b0;

    // first read after reset fetches the reset pc
    assert (inst_sram_ren === 1'b1)
      else report_mismatch("o_inst_sram_ren", xlen_t'(inst_sram_ren), xlen_t'(1));
    assert (inst_sram_addr === PC_RESET[31:0])
      else report_mismatch("o_inst_sram_addr", xlen_t'(inst_sram_addr),
                           xlen_t'(PC_RESET[31:0]));

    // counters settle at the falling edge, read them at the rising one
    while (commit_count < N_COMMITS && cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
    end
    if (commit_count < N_COMMITS) begin
      err_count++;
      $display("timeout: only %0d of %0d instructions retired in %0d cycles",
               commit_count, N_COMMITS, cycle_count);
    end

    $display("commits checked %0d, errors %0d", commit_count, err_count);
    if (err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* tb.f */
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/core_top.sv
dv/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ns
PASS_MSG  := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir
